// File: source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// widths fixed by the ISA and the read bus
	typedef logic [63:0] addr_t;
	typedef logic [31:0] instr_t;
	typedef logic [63:0] bus_data_t;
	typedef logic [1:0]  bus_resp_t; // 0 is okay, anything else is an error
	typedef logic [7:0]  bus_len_t;
	typedef logic [2:0]  bus_size_t;

	localparam addr_t       reset_pc    = 64'h8000_0000;
	localparam bus_size_t   size_dword  = 3'd3; // 8 bytes per beat
	localparam int unsigned queue_depth = 4;

	// coarse class of opcode bits 6..0, enough for decode to steer early
	typedef enum logic [2:0] {
		op_alu,
		op_load,
		op_store,
		op_branch,
		op_jal,
		op_jalr,
		op_system,
		op_other
	} opclass_t;

	// one fetched instruction with its addresses
	typedef struct packed {
		addr_t  pc;
		addr_t  snpc;   // pc + 4
		instr_t instr;  // zero when fault is set
		logic   fault;  // bus returned an error response
	} fetch_entry_t;

	// what predecode hands to decode
	typedef struct packed {
		fetch_entry_t entry;
		opclass_t     opclass;
		addr_t        jal_target; // pc + J immediate, valid for any entry
	} decode_out_t;

	// single outstanding read
	typedef enum logic [1:0] {
		idle,
		wait_ar,
		wait_r
	} fetch_state_t;

endpackage

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import fetch_pkg::*; (
	input  wire logic      clk,
	input  wire logic      reset,
	input  wire logic      redirect_valid,
	input  wire addr_t     redirect_pc,
	input  wire logic      ar_ready,
	input  wire logic      r_valid,
	input  wire bus_data_t r_data,
	input  wire bus_resp_t r_resp,
	output logic           ar_valid,
	output addr_t          ar_addr,
	output bus_len_t       ar_len,
	output bus_size_t      ar_size,
	input  wire logic [2:0] queue_count,
	output logic           push,
	output fetch_entry_t   push_entry
);

	fetch_state_t state;
	addr_t        pc;      // address of the read in flight, or of the next one
	addr_t        snpc;
	logic         drop;    // in-flight read belongs to a path that was redirected away
	logic [3:0]   count_ext;
	logic         can_issue;
	logic         can_chain;
	logic         resp_err;
	instr_t       word;

	// the bus always moves whole doublewords, the word is picked locally
	function automatic addr_t dword_addr(input addr_t a);
		return {a[63:3], 3'b000};
	endfunction

	assign snpc = pc + 64'd4;

	// credit against the queue; a read is only started when its entry is sure to fit
	assign count_ext = {1'b0, queue_count};
	assign can_issue = (count_ext + 4'd1) <= 4'(queue_depth);
	// chaining from a response: the entry pushed this cycle is not yet in queue_count
	assign can_chain = (count_ext + 4'd2) <= 4'(queue_depth);

	assign ar_valid = (state == wait_ar);
	assign ar_len   = '0;          // single beat
	assign ar_size  = size_dword;

	assign resp_err = (r_resp != '0);
	assign word     = pc[2] ? r_data[63:32] : r_data[31:0];

	// response goes straight into the queue, unless it is stale or a redirect hits now
	assign push = (state == wait_r) && r_valid && !drop && !redirect_valid;

	always_comb begin
		push_entry.pc    = pc;
		push_entry.snpc  = snpc;
		push_entry.fault = resp_err;
		push_entry.instr = resp_err ? '0 : word;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			pc    <= reset_pc;
			drop  <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (redirect_valid) begin
						pc <= redirect_pc; // nothing in flight, just retarget
					end else if (can_issue) begin
						state   <= wait_ar;
						ar_addr <= dword_addr(pc);
					end
				end

				wait_ar: begin
					// address stays on the bus until taken, a redirect only marks it stale
					if (redirect_valid) begin
						pc   <= redirect_pc;
						drop <= 1'b1;
					end
					if (ar_ready) begin
						state <= wait_r;
					end
				end

				wait_r: begin
					if (r_valid) begin
						if (redirect_valid) begin
							pc    <= redirect_pc;
							drop  <= 1'b0;
							state <= idle;
						end else if (drop) begin
							drop  <= 1'b0; // stale beat discarded, pc already retargeted
							state <= idle;
						end else begin
							pc <= snpc;
							if (can_chain) begin
								state   <= wait_ar; // back to back request
								ar_addr <= dword_addr(snpc);
							end else begin
								state <= idle;
							end
						end
					end else if (redirect_valid) begin
						pc   <= redirect_pc;
						drop <= 1'b1;
					end
				end

				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/fetch_queue.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_queue import fetch_pkg::*; (
	input  wire logic          clk,
	input  wire logic          reset,
	input  wire logic          flush,
	input  wire logic          push,
	input  wire fetch_entry_t  push_entry,
	input  wire logic          pop,
	output logic               head_valid,
	output fetch_entry_t       head_entry,
	output logic [2:0]         count
);

	fetch_entry_t mem [queue_depth];
	logic [1:0]   wr_ptr;   // wraps naturally at four entries
	logic [1:0]   rd_ptr;
	logic         do_push;
	logic         do_pop;
	logic         full;

	assign head_valid = (count != 3'd0);
	assign head_entry = mem[rd_ptr];
	assign full       = (count == 3'(queue_depth));

	assign do_pop  = pop && head_valid;
	// producer checks credit, a full queue can still take one if the head leaves now
	assign do_push = push && (!full || do_pop);

	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 2'd1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 2'd1;
			end
		end
	end

	// occupancy, used by the fetch unit for its credit check
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			count <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10:   count <= count + 3'd1;
				2'b01:   count <= count - 3'd1;
				default: count <= count; // none, or push and pop together
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/predecode.sv
`timescale 1ns/100ps
`default_nettype none

module predecode import fetch_pkg::*; (
	input  wire logic         clk,
	input  wire logic         reset,
	input  wire logic         flush,
	input  wire logic         head_valid,
	input  wire fetch_entry_t head_entry,
	output logic              pop,
	output logic              out_valid,
	input  wire logic         out_ready,
	output decode_out_t       out_data
);

	decode_out_t out_q;
	opclass_t    head_class;
	addr_t       j_imm;
	addr_t       head_target;

	// major opcode table, rv64i base plus the 32-bit word forms
	function automatic opclass_t classify(input instr_t instr, input logic fault);
		opclass_t c;
		if (fault) begin
			c = op_other;
		end else begin
			case (instr[6:0])
				7'b0110011, 7'b0010011: c = op_alu;
				7'b0111011, 7'b0011011: c = op_alu;   // *w variants
				7'b0110111, 7'b0010111: c = op_alu;   // lui, auipc
				7'b0000011:             c = op_load;
				7'b0100011:             c = op_store;
				7'b1100011:             c = op_branch;
				7'b1101111:             c = op_jal;
				7'b1100111:             c = op_jalr;
				7'b1110011:             c = op_system;
				default:                c = op_other; // fence and anything unknown
			endcase
		end
		return c;
	endfunction

	assign head_class = classify(head_entry.instr, head_entry.fault);

	// J-type immediate, computed for every entry, decode only uses it for jal
	assign j_imm = {{44{head_entry.instr[31]}}, head_entry.instr[19:12],
		head_entry.instr[20], head_entry.instr[30:21], 1'b0};
	assign head_target = head_entry.pc + j_imm;

	// take a new entry when the register is empty or draining this cycle
	assign pop = head_valid && (!out_valid || out_ready);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			out_valid <= 1'b0;
		end else if (pop) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			out_q.entry      <= head_entry;
			out_q.opclass    <= head_class;
			out_q.jal_target <= head_target;
		end
	end

	assign out_data = out_q; // held while out_ready is low

endmodule

`default_nettype wire

// File: source/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
	input  wire logic      clk,
	input  wire logic      reset,
	input  wire logic      redirect_valid,
	input  wire addr_t     redirect_pc,
	// read address channel
	output logic           ar_valid,
	input  wire logic      ar_ready,
	output addr_t          ar_addr,
	output bus_len_t       ar_len,
	output bus_size_t      ar_size,
	// read data channel, always accepted
	input  wire logic      r_valid,
	input  wire bus_data_t r_data,
	input  wire bus_resp_t r_resp,
	// towards decode
	output logic           out_valid,
	input  wire logic      out_ready,
	output decode_out_t    out_data
);

	logic         push;
	fetch_entry_t push_entry;
	logic         pop;
	logic         head_valid;
	fetch_entry_t head_entry;
	logic [2:0]   queue_count;

	fetch_unit i_fetch_unit (
		.clk            (clk),
		.reset          (reset),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.ar_ready       (ar_ready),
		.r_valid        (r_valid),
		.r_data         (r_data),
		.r_resp         (r_resp),
		.ar_valid       (ar_valid),
		.ar_addr        (ar_addr),
		.ar_len         (ar_len),
		.ar_size        (ar_size),
		.queue_count    (queue_count),
		.push           (push),
		.push_entry     (push_entry)
	);

	// redirect flushes everything younger than the redirecting stage
	fetch_queue i_fetch_queue (
		.clk        (clk),
		.reset      (reset),
		.flush      (redirect_valid),
		.push       (push),
		.push_entry (push_entry),
		.pop        (pop),
		.head_valid (head_valid),
		.head_entry (head_entry),
		.count      (queue_count)
	);

	predecode i_predecode (
		.clk        (clk),
		.reset      (reset),
		.flush      (redirect_valid),
		.head_valid (head_valid),
		.head_entry (head_entry),
		.pop        (pop),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_data   (out_data)
	);

endmodule

`default_nettype wire

// File: test/fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

	localparam int max_lines = 64;

	logic        clk;
	logic        reset;
	logic        redirect_valid;
	addr_t       redirect_pc;
	logic        ar_valid;
	logic        ar_ready;
	addr_t       ar_addr;
	bus_len_t    ar_len;
	bus_size_t   ar_size;
	logic        r_valid;
	bus_data_t   r_data;
	bus_resp_t   r_resp;
	logic        out_valid;
	logic        out_ready;
	decode_out_t out_data;

	// memory image, error list, redirects and expected stream
	addr_t     mem_addr [max_lines];
	bus_data_t mem_data [max_lines];
	addr_t     err_addr [max_lines];
	integer    redir_after [max_lines];
	addr_t     redir_pc [max_lines];
	addr_t     exp_pc [max_lines];
	instr_t    exp_instr [max_lines];
	integer    exp_class [max_lines];
	addr_t     exp_target [max_lines];
	integer    exp_test [max_lines];
	logic [8*16-1:0] test_name [8];
	integer    test_stall [8];
	integer    test_outputs [8];
	integer    test_errors [8];
	integer    n_mem, n_err, n_redir, n_exp, n_test;

	integer seed = 32'h9614;
	integer checks, errors, cycles, limit, out_idx, redir_next, cur_test;
	logic   timed_out;
	logic   busy;      // address accepted, response not yet given
	logic   pending;   // response still to be driven
	integer resp_wait;
	addr_t  req_addr;
	logic   ar_hs, out_hs;
	addr_t  ar_addr_s;
	decode_out_t got;

	fetch_top i_dut (
		.clk            (clk),
		.reset          (reset),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.ar_valid       (ar_valid),
		.ar_ready       (ar_ready),
		.ar_addr        (ar_addr),
		.ar_len         (ar_len),
		.ar_size        (ar_size),
		.r_valid        (r_valid),
		.r_data         (r_data),
		.r_resp         (r_resp),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.out_data       (out_data)
	);

	always #4 clk = ~clk;

	function automatic bus_data_t mem_read(input addr_t a);
		bus_data_t d;
		integer    i;
		d = a ^ {a[31:0], a[63:32]} ^ 64'h5a5a_0f0f_a5a5_f0f0; // unlisted doublewords
		for (i = 0; i < n_mem; i++) begin
			if (mem_addr[i] == a) d = mem_data[i];
		end
		return d;
	endfunction

	function automatic logic is_error(input addr_t a);
		logic   hit;
		integer i;
		hit = 1'b0;
		for (i = 0; i < n_err; i++) begin
			if (err_addr[i] == {a[63:3], 3'b000}) hit = 1'b1;
		end
		return hit;
	endfunction

	task automatic compare(input string field, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (act == exp) else begin
			$display("ERR %0s %0s expected %h actual %h", test_name[cur_test], field, exp, act);
			errors++;
			test_errors[cur_test]++;
		end
	endtask

	task automatic check_output(input decode_out_t d);
		addr_t pc;
		pc = exp_pc[out_idx];
		cur_test = exp_test[out_idx];
		compare("pc", pc, d.entry.pc);
		compare("snpc", pc + 64'd4, d.entry.snpc);
		compare("instr", exp_instr[out_idx], d.entry.instr);
		compare("fault", is_error(pc), d.entry.fault);
		compare("opclass", exp_class[out_idx], d.opclass);
		compare("jal_target", exp_target[out_idx], d.jal_target);
		test_outputs[cur_test]++;
		out_idx++;
		if (out_idx == n_exp || exp_test[out_idx] != cur_test) begin
			$display("test %0s: %0d outputs, %0d errors", test_name[cur_test],
				test_outputs[cur_test], test_errors[cur_test]);
		end
	endtask

	task automatic load_testdata;
		integer fd, code, k, cls, stall;
		logic [8*16-1:0]  tag;
		logic [8*16-1:0]  name;
		logic [8*128-1:0] rest;
		addr_t     a;
		addr_t     t;
		bus_data_t d;
		instr_t    ins;
		fd = $fopen("test/fetch_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open test/fetch_testdata.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", tag);
				if (code == 1) begin
					case (tag)
						"#": code = $fgets(rest, fd);
						"m": begin
							code = $fscanf(fd, "%h %h", a, d);
							mem_addr[n_mem] = a;
							mem_data[n_mem] = d;
							n_mem++;
						end
						"e": begin
							code = $fscanf(fd, "%h", a);
							err_addr[n_err] = a;
							n_err++;
						end
						"r": begin
							code = $fscanf(fd, "%d %h", k, a);
							redir_after[n_redir] = k;
							redir_pc[n_redir] = a;
							n_redir++;
						end
						"t": begin
							code = $fscanf(fd, "%s %d", name, stall);
							test_name[n_test] = name;
							test_stall[n_test] = stall;
							n_test++;
						end
						"x": begin
							code = $fscanf(fd, "%h %h %d %h", a, ins, cls, t);
							exp_pc[n_exp] = a;
							exp_instr[n_exp] = ins;
							exp_class[n_exp] = cls;
							exp_target[n_exp] = t;
							exp_test[n_exp] = n_test - 1;
							n_exp++;
						end
						default: begin
							$display("unknown line in test data file");
							errors++;
						end
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r_data = '0;
		r_resp = '0;
		out_ready = 1'b0;
		{n_mem, n_err, n_redir, n_exp, n_test} = '0;
		{checks, errors, cycles, out_idx, redir_next, cur_test} = '0;
		{timed_out, busy, pending} = '0;
		resp_wait = 0;
		req_addr = '0;
		for (int i = 0; i < 8; i++) begin
			test_outputs[i] = 0;
			test_errors[i] = 0;
		end
		load_testdata();
		limit = 40 * n_exp;
		repeat (2) @(posedge clk);
		@(negedge clk);
		assert (!ar_valid && !out_valid) else begin
			$display("bus request or output active during reset");
			errors++;
		end
		@(posedge clk);
		#1;
		reset = 1'b0;

		while (out_idx < n_exp && !timed_out) begin
			@(negedge clk); // inputs settled, sample what the next edge will transfer
			ar_hs = ar_valid && ar_ready;
			out_hs = out_valid && out_ready;
			ar_addr_s = ar_addr;
			got = out_data;
			if (ar_valid) begin
				assert (!busy) else begin
					$display("read request issued while another read is outstanding");
					errors++;
				end
				assert (ar_len == '0 && ar_size == size_dword && ar_addr[2:0] == 3'b000) else begin
					$display("read request is not a single aligned doubleword");
					errors++;
				end
			end
			@(posedge clk);
			#1;
			cycles++;
			if (out_hs) check_output(got);

			// bus slave, one beat per request after 0 to 3 idle cycles
			if (r_valid) begin
				r_valid = 1'b0;
				r_resp = '0;
				busy = 1'b0;
			end
			if (ar_hs) begin
				busy = 1'b1;
				pending = 1'b1;
				req_addr = ar_addr_s;
				resp_wait = $random(seed) & 3;
			end
			if (pending) begin
				if (resp_wait == 0) begin
					r_valid = 1'b1;
					r_data = mem_read(req_addr);
					r_resp = is_error(req_addr) ? 2'b10 : 2'b00;
					pending = 1'b0;
				end else begin
					resp_wait--;
				end
			end
			ar_ready = ($random(seed) & 3) != 0;

			// decode side
			redirect_valid = 1'b0;
			if (out_hs && redir_next < n_redir && redir_after[redir_next] == out_idx - 1) begin
				redirect_valid = 1'b1;
				redirect_pc = redir_pc[redir_next];
				redir_next++;
				out_ready = 1'b0; // redirecting stage takes nothing this cycle
			end else if (out_idx < n_exp && test_stall[exp_test[out_idx]] != 0) begin
				out_ready = ($random(seed) & 7) == 0; // long stalls fill the queue
			end else begin
				out_ready = ($random(seed) & 3) != 0;
			end

			if (cycles >= limit) begin
				$display("timeout after %0d cycles, %0d of %0d outputs seen", cycles, out_idx, n_exp);
				timed_out = 1'b1;
			end
		end

		$display("%0d checks, %0d errors, %0d of %0d outputs", checks, errors, out_idx, n_exp);
		if (errors == 0 && !timed_out && n_exp > 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
source/fetch_pkg.sv
source/fetch_unit.sv
source/fetch_queue.sv
source/predecode.sv
source/fetch_top.sv
test/fetch_tb.sv

// File: test/fetch_testdata.txt
# m dword_addr data64 | e error_dword_addr | r after_output_index target_pc
# t test_name stall_mode | x pc instr class jal_target (class 0 alu .. 7 other)
m 80000000 0010009300000013
m 80000008 0000001300208113
m 80000010 0031342300013183
m 80000018 1000006ffe009ee3
m 80000020 0000007300008067
m 80000028 0ff0000f123452b7
m 80000030 0000031700000013
m 80000038 000004330000039b
m 80000100 0000001300100093
m 80000200 0000001300100073
m 80000208 00a0051300500293
m 80000210 0010009300000013
e 80000208
r 15 80000100
r 17 80000200
t seq 0
x 80000000 00000013 0 80000000
x 80000004 00100093 0 80000804
x 80000008 00208113 0 8000800a
x 8000000c 00000013 0 8000000c
t class 0
x 80000010 00013183 1 80013010
x 80000014 00313423 2 80013816
x 80000018 fe009ee3 3 7ff097f8
x 8000001c 1000006f 4 8000011c
x 80000020 00008067 5 80008020
x 80000024 00000073 6 80000024
t backpressure 1
x 80000028 123452b7 0 8004594a
x 8000002c 0ff0000f 7 8000092a
x 80000030 00000013 0 80000030
x 80000034 00000317 0 80000034
x 80000038 0000039b 0 80000038
x 8000003c 00000433 0 8000003c
t redirect 0
x 80000100 00100093 0 80000900
x 80000104 00000013 0 80000104
x 80000200 00100073 6 80000a00
x 80000204 00000013 0 80000204
t buserr 0
x 80000208 00000000 7 80000208
x 8000020c 00000000 7 8000020c
x 80000210 00000013 0 80000210
x 80000214 00100093 0 80000a14
